// ==== src/mrd_pkg.sv ====
// shared constants for the mixed-radix DFT memory subsystem; import where needed
`default_nettype none

package mrd_pkg;

	// ------------------------------------------------------------------------
	// frame geometry
	// ------------------------------------------------------------------------
	// 60 = 4 * 5 * 3
	localparam int DFT_PTS = 60;
	localparam int ADDR_W = 6;
	// 16-bit real in the upper half, 16-bit imaginary in the lower half
	localparam int DATA_W = 32;
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DFT_PTS - 1);

	// ------------------------------------------------------------------------
	// stage factors
	// ------------------------------------------------------------------------
	localparam int NUM_STAGES = 3;
	localparam int STAGE_W = 2;
	// radix per stage, in processing order
	localparam int NF_TABLE [NUM_STAGES] = '{4, 5, 3};
	// transpose stride, frame length over radix
	localparam int STRIDE_TABLE [NUM_STAGES] = '{DFT_PTS / 4, DFT_PTS / 5, DFT_PTS / 3};

	// bank state codes
	localparam logic [1:0] BANK_SINK = 2'b00;
	localparam logic [1:0] BANK_RD = 2'b01;
	localparam logic [1:0] BANK_WR = 2'b10;
	localparam logic [1:0] BANK_SOURCE = 2'b11;

	// controller FSM codes
	localparam logic [1:0] FSM_WAIT = 2'd0;
	localparam logic [1:0] FSM_SINK = 2'd1;
	localparam logic [1:0] FSM_COMPUTE = 2'd2;
	localparam logic [1:0] FSM_SOURCE = 2'd3;

endpackage

`default_nettype wire

// ==== src/mrd_stride_addr.sv ====
// write-address generator; transpose permutation for the radix of the current stage
`default_nettype none

module mrd_stride_addr (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        wr_valid,
	input  logic [mrd_pkg::STAGE_W-1:0] stage,
	output logic [mrd_pkg::ADDR_W-1:0]  wr_addr
);
	import mrd_pkg::*;

	logic [2:0] nf;
	logic [ADDR_W-1:0] stride;
	// current output address, (i mod nf) * stride + i div nf
	logic [ADDR_W-1:0] acc;
	// position inside the group of nf writes
	logic [2:0] digit;
	logic [ADDR_W:0] acc_step;
	logic wr_valid_r;

	// table lookup, stage 0 also covers unused codes
	always_comb
	begin
		nf = 3'(NF_TABLE[0]);
		stride = ADDR_W'(STRIDE_TABLE[0]);
		for (int s = 1; s < NUM_STAGES; s++)
		begin
			if (stage == STAGE_W'(s))
			begin
				nf = 3'(NF_TABLE[s]);
				stride = ADDR_W'(STRIDE_TABLE[s]);
			end
		end
	end

	assign acc_step = {1'b0, acc} + {1'b0, stride};
	assign wr_addr = acc;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			acc <= '0;
			digit <= '0;
			wr_valid_r <= 1'b0;
		end
		else
		begin
			wr_valid_r <= wr_valid;
			if (wr_valid)
			begin
				if (digit == nf - 3'd1)
				begin
					// nf * stride = frame length, so this wraps to the next column
					digit <= '0;
					acc <= ADDR_W'(acc_step - (ADDR_W + 1)'(DFT_PTS - 1));
				end
				else
				begin
					digit <= digit + 3'd1;
					acc <= acc_step[ADDR_W-1:0];
				end
			end
			// end of pass, ready for the next stage
			else if (wr_valid_r)
			begin
				acc <= '0;
				digit <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/mrd_mem_bank.sv ====
// one ping-pong bank; sinks, reads or writes a stage, or sources a frame by its state code
`default_nettype none

module mrd_mem_bank (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [1:0]                 state,
	input  logic                       sink_valid,
	input  logic                       sink_sop,
	input  logic [mrd_pkg::DATA_W-1:0] sink_data,
	input  logic                       wr_valid,
	input  logic [mrd_pkg::ADDR_W-1:0] wr_addr,
	input  logic [mrd_pkg::DATA_W-1:0] wr_data,
	output logic                       rd_valid,
	output logic [mrd_pkg::DATA_W-1:0] rd_data,
	output logic                       sink_busy,
	output logic                       source_busy,
	output logic                       wr_busy,
	output logic                       source_valid,
	output logic                       source_sop,
	output logic                       source_eop,
	output logic [mrd_pkg::DATA_W-1:0] source_data
);
	import mrd_pkg::*;

	logic [DATA_W-1:0] mem [DFT_PTS];
	logic [DATA_W-1:0] mem_q;
	logic [1:0] state_r;
	logic [ADDR_W-1:0] sink_addr;
	logic [ADDR_W-1:0] scan_addr;
	logic [ADDR_W-1:0] wr_cnt;
	logic [ADDR_W-1:0] mem_waddr;
	logic [DATA_W-1:0] mem_wdata;
	logic sink_we;
	logic stage_we;
	logic scan_on;
	logic scan_start;
	logic scan_last;
	logic src_scan;

	// ------------------------------------------------------------------------
	// write port, shared by sink and stage writes
	// ------------------------------------------------------------------------
	// stray words outside a frame are dropped
	assign sink_we = (state == BANK_SINK) && sink_valid && (sink_sop || sink_busy);
	assign stage_we = (state == BANK_WR) && wr_valid;
	assign mem_waddr = stage_we ? wr_addr : (sink_sop ? '0 : sink_addr);
	assign mem_wdata = stage_we ? wr_data : sink_data;

	// read latency 1
	always_ff @(posedge clk)
	begin
		if (sink_we || stage_we)
			mem[mem_waddr] <= mem_wdata;
		if (scan_on)
			mem_q <= mem[scan_addr];
	end

	// ------------------------------------------------------------------------
	// sequential scan, used for stage reads and for source
	// ------------------------------------------------------------------------
	// restarts on every entry into RD or SOURCE
	assign scan_start = ((state == BANK_RD) || (state == BANK_SOURCE)) && (state != state_r);
	assign scan_last = scan_addr == LAST_ADDR;
	assign src_scan = scan_on && (state == BANK_SOURCE);

	assign rd_valid = scan_on && (state == BANK_RD);
	assign rd_data = mem_q;
	assign source_data = mem_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_r <= BANK_SINK;
			scan_on <= 1'b0;
			scan_addr <= '0;
			sink_addr <= '0;
			sink_busy <= 1'b0;
			wr_cnt <= '0;
			wr_busy <= 1'b0;
			source_busy <= 1'b0;
			source_valid <= 1'b0;
			source_sop <= 1'b0;
			source_eop <= 1'b0;
		end
		else
		begin
			state_r <= state;

			// scan counter
			if (scan_start)
			begin
				scan_on <= 1'b1;
				scan_addr <= '0;
			end
			else if (scan_on)
			begin
				scan_on <= !scan_last;
				scan_addr <= scan_last ? '0 : scan_addr + 1'b1;
			end

			// sink pass, sop word lands at 0
			if (sink_we)
			begin
				if (sink_sop)
				begin
					sink_addr <= ADDR_W'(1);
					sink_busy <= 1'b1;
				end
				else if (sink_addr == LAST_ADDR)
				begin
					sink_addr <= '0;
					sink_busy <= 1'b0;
				end
				else
					sink_addr <= sink_addr + 1'b1;
			end

			// stage write pass, busy until the 60th write
			if ((state == BANK_WR) && (state_r != BANK_WR))
			begin
				wr_busy <= 1'b1;
				wr_cnt <= '0;
			end
			else if (stage_we)
			begin
				if (wr_cnt == LAST_ADDR)
					wr_busy <= 1'b0;
				wr_cnt <= (wr_cnt == LAST_ADDR) ? '0 : wr_cnt + 1'b1;
			end

			// source framing, aligned with mem_q
			source_valid <= src_scan;
			source_sop <= src_scan && (scan_addr == '0);
			source_eop <= src_scan && scan_last;
			if (scan_start && (state == BANK_SOURCE))
				source_busy <= 1'b1;
			else if (source_eop)
				source_busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== src/mrd_ctrl_fsm.sv ====
// frame controller; sequences sink, the radix stages and source over the two ping-pong banks
`default_nettype none

module mrd_ctrl_fsm (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        sink_sop,
	input  logic                        sink_busy0,
	input  logic                        sink_busy1,
	input  logic                        source_busy0,
	input  logic                        source_busy1,
	input  logic                        wr_busy0,
	input  logic                        wr_busy1,
	output logic [1:0]                  bank0_state,
	output logic [1:0]                  bank1_state,
	output logic [mrd_pkg::STAGE_W-1:0] stage,
	output logic                        sw_in,
	output logic                        sw_out,
	output logic                        xfer_1to0,
	output logic                        sink_idle
);
	import mrd_pkg::*;

	logic [1:0] fsm;
	logic [STAGE_W-1:0] cnt_stage;
	// delayed copy keeps the bank states steady on the last count
	logic [STAGE_W-1:0] cnt_stage_r;
	logic wr_busy0_r;
	logic wr_busy1_r;
	logic stage_done;
	logic bank_swap;

	// falling wr_busy of whichever bank is writing
	assign stage_done = (xfer_1to0 && !wr_busy0 && wr_busy0_r)
		|| (!xfer_1to0 && !wr_busy1 && wr_busy1_r);

	// bank0 writes when this is set
	assign bank_swap = sw_in ^ cnt_stage_r[0];

	// new frame may start only in wait, and never into a sourcing bank
	assign sink_idle = (fsm == FSM_WAIT)
		&& ((sw_in ? bank1_state : bank0_state) != BANK_SOURCE);

	// ------------------------------------------------------------------------
	// main FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			fsm <= FSM_WAIT;
		else
		begin
			case (fsm)
				// idle, previous frame may still be sourcing
				FSM_WAIT:
					if (sink_sop)
						fsm <= FSM_SINK;
				// wait until sink done and the other bank drained
				FSM_SINK:
					if (!sink_busy0 && !sink_busy1 && !source_busy0 && !source_busy1)
						fsm <= FSM_COMPUTE;
				FSM_COMPUTE:
					if (cnt_stage == STAGE_W'(NUM_STAGES))
						fsm <= FSM_SOURCE;
				// single cycle, kicks the source pass
				default:
					fsm <= FSM_WAIT;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// stage counter
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cnt_stage <= '0;
			cnt_stage_r <= '0;
			wr_busy0_r <= 1'b0;
			wr_busy1_r <= 1'b0;
		end
		else
		begin
			cnt_stage_r <= cnt_stage;
			wr_busy0_r <= wr_busy0;
			wr_busy1_r <= wr_busy1;
			if (fsm != FSM_COMPUTE)
				cnt_stage <= '0;
			else if (stage_done)
				cnt_stage <= cnt_stage + 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// bank states and steering flags
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			bank0_state <= BANK_SINK;
			bank1_state <= BANK_SINK;
			stage <= '0;
			sw_in <= 1'b0;
			sw_out <= 1'b0;
			xfer_1to0 <= 1'b0;
		end
		else
		begin
			case (fsm)
				FSM_COMPUTE:
				begin
					// ping-pong, one bank reads while the other takes the permuted frame
					bank0_state <= bank_swap ? BANK_WR : BANK_RD;
					bank1_state <= bank_swap ? BANK_RD : BANK_WR;
					stage <= cnt_stage_r;
					xfer_1to0 <= bank_swap;
					// odd stage count leaves the result in the other bank
					sw_out <= (NUM_STAGES % 2 == 1) ? ~sw_in : sw_in;
				end
				FSM_SOURCE:
				begin
					bank0_state <= sw_out ? BANK_SINK : BANK_SOURCE;
					bank1_state <= sw_out ? BANK_SOURCE : BANK_SINK;
					stage <= '0;
					xfer_1to0 <= 1'b0;
					// next frame goes to the bank not holding the result
					sw_in <= ~sw_out;
				end
				default:
				begin
					// sink bank to SINK, the other keeps sourcing
					if (!sw_in)
						bank0_state <= BANK_SINK;
					if (sw_in)
						bank1_state <= BANK_SINK;
					stage <= '0;
					xfer_1to0 <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/mrd_dft_top.sv ====
// top level of the DFT memory subsystem; instantiate with a strobe sink and a streaming source
`default_nettype none

module mrd_dft_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       sink_valid,
	input  logic                       sink_sop,
	input  logic [mrd_pkg::DATA_W-1:0] sink_data,
	output logic                       sink_idle,
	output logic                       source_valid,
	output logic                       source_sop,
	output logic                       source_eop,
	output logic [mrd_pkg::DATA_W-1:0] source_data
);
	import mrd_pkg::*;

	logic [1:0] bank0_state;
	logic [1:0] bank1_state;
	logic [STAGE_W-1:0] stage;
	logic sw_in;
	logic sw_out;
	logic xfer_1to0;
	logic sink_busy0, sink_busy1;
	logic source_busy0, source_busy1;
	logic wr_busy0, wr_busy1;
	logic rd_valid0, rd_valid1;
	logic [DATA_W-1:0] rd_data0, rd_data1;
	logic src_valid0, src_valid1;
	logic src_sop0, src_sop1;
	logic src_eop0, src_eop1;
	logic [DATA_W-1:0] src_data0, src_data1;
	logic wr_valid;
	logic [ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0] wr_data;

	// ------------------------------------------------------------------------
	// controller and address generator
	// ------------------------------------------------------------------------
	mrd_ctrl_fsm u_ctrl (
		.clk(clk), .rst_n(rst_n), .sink_sop(sink_sop),
		.sink_busy0(sink_busy0), .sink_busy1(sink_busy1),
		.source_busy0(source_busy0), .source_busy1(source_busy1),
		.wr_busy0(wr_busy0), .wr_busy1(wr_busy1),
		.bank0_state(bank0_state), .bank1_state(bank1_state), .stage(stage),
		.sw_in(sw_in), .sw_out(sw_out), .xfer_1to0(xfer_1to0), .sink_idle(sink_idle)
	);

	mrd_stride_addr u_addr (
		.clk(clk), .rst_n(rst_n), .wr_valid(wr_valid), .stage(stage), .wr_addr(wr_addr)
	);

	// rd valid delayed one cycle to meet the registered read data
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			wr_valid <= 1'b0;
		else
			wr_valid <= xfer_1to0 ? rd_valid1 : rd_valid0;
	end

	assign wr_data = xfer_1to0 ? rd_data1 : rd_data0;

	// ------------------------------------------------------------------------
	// banks, sink strobes steered by sw_in
	// ------------------------------------------------------------------------
	mrd_mem_bank u_bank0 (
		.clk(clk), .rst_n(rst_n), .state(bank0_state),
		.sink_valid(sink_valid && !sw_in), .sink_sop(sink_sop && !sw_in),
		.sink_data(sink_data), .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_valid(rd_valid0), .rd_data(rd_data0), .sink_busy(sink_busy0),
		.source_busy(source_busy0), .wr_busy(wr_busy0), .source_valid(src_valid0),
		.source_sop(src_sop0), .source_eop(src_eop0), .source_data(src_data0)
	);

	mrd_mem_bank u_bank1 (
		.clk(clk), .rst_n(rst_n), .state(bank1_state),
		.sink_valid(sink_valid && sw_in), .sink_sop(sink_sop && sw_in),
		.sink_data(sink_data), .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_valid(rd_valid1), .rd_data(rd_data1), .sink_busy(sink_busy1),
		.source_busy(source_busy1), .wr_busy(wr_busy1), .source_valid(src_valid1),
		.source_sop(src_sop1), .source_eop(src_eop1), .source_data(src_data1)
	);

	// output mux
	assign source_valid = sw_out ? src_valid1 : src_valid0;
	assign source_sop = sw_out ? src_sop1 : src_sop0;
	assign source_eop = sw_out ? src_eop1 : src_eop0;
	assign source_data = sw_out ? src_data1 : src_data0;

endmodule

`default_nettype wire

// ==== tb/mrd_dft_asserts.sv ====
// concurrent checks on the controller bank states; bound into every mrd_ctrl_fsm instance
`default_nettype none

module mrd_dft_asserts (
	input logic                        clk,
	input logic                        rst_n,
	input logic [1:0]                  bank0_state,
	input logic [1:0]                  bank1_state,
	input logic [mrd_pkg::STAGE_W-1:0] stage
);
	timeunit 1ns;
	timeprecision 1ps;
	import mrd_pkg::*;

	// equal codes only while both banks sink
	a_state_pair: assert property (@(posedge clk) disable iff (!rst_n)
		(bank0_state == bank1_state) |-> (bank0_state == BANK_SINK))
		else $error("both banks hold the same state code outside of sink");

	// stage index stays in the factor table during a write pass
	a_stage_range: assert property (@(posedge clk) disable iff (!rst_n)
		((bank0_state == BANK_WR) || (bank1_state == BANK_WR))
		|-> (stage < STAGE_W'(NUM_STAGES)))
		else $error("stage index out of range while a bank is writing");

endmodule

bind mrd_ctrl_fsm mrd_dft_asserts u_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.bank0_state(bank0_state),
	.bank1_state(bank1_state),
	.stage(stage)
);

`default_nettype wire

// ==== tb/mrd_dft_checker.sv ====
// scoreboard beside the DUT; captures sink frames, permutes them and compares the source stream
`default_nettype none

module mrd_dft_checker (
	input  logic                       clk,
	input  logic                       rst_n,
	input  int                         test_id,
	input  logic                       sink_valid,
	input  logic                       sink_sop,
	input  logic [mrd_pkg::DATA_W-1:0] sink_data,
	input  logic                       sink_idle,
	input  logic                       source_valid,
	input  logic                       source_sop,
	input  logic                       source_eop,
	input  logic [mrd_pkg::DATA_W-1:0] source_data,
	output int                         error_count,
	output int                         frames_done
);
	timeunit 1ns;
	timeprecision 1ps;
	import mrd_pkg::*;

	typedef logic [DFT_PTS-1:0][DATA_W-1:0] frame_t;

	// stage radices in processing order
	localparam int RADIX [3] = '{4, 5, 3};

	frame_t cap;
	frame_t expected;
	logic [DATA_W-1:0] exp_q [$];
	int tid_q [$];
	int cap_idx;
	int out_idx;
	int b2b_sops;
	logic idle_phase;
	logic [DATA_W-1:0] want;
	string name;

	initial
	begin
		error_count = 0;
		frames_done = 0;
	end

	function automatic string test_name(input int id);
		case (id)
			0: return "reset_idle";
			1: return "count_frame";
			2: return "random_gaps";
			default: return "back_to_back";
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// reference model with one transpose per stage
	// ------------------------------------------------------------------------
	function automatic frame_t ref_frame(input frame_t din);
		frame_t cur;
		frame_t nxt;
		int nf;
		int stride;
		cur = din;
		nxt = '0;
		for (int s = 0; s < 3; s++)
		begin
			nf = RADIX[s];
			stride = DFT_PTS / nf;
			// sample i goes to row i mod nf and column i div nf
			for (int i = 0; i < DFT_PTS; i++)
				nxt[(i % nf) * stride + i / nf] = cur[i];
			cur = nxt;
		end
		return cur;
	endfunction

	task automatic report_mismatch(input string tname, input string what, input int word,
		input logic [DATA_W-1:0] exp_val, input logic [DATA_W-1:0] act_val);
		$display("** Error [%s] %s at word %0d: expected %08h, actual %08h",
			tname, what, word, exp_val, act_val);
		error_count++;
	endtask

	// ------------------------------------------------------------------------
	// capture, idle window and output compare
	// ------------------------------------------------------------------------
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			cap_idx = 0;
			out_idx = 0;
			b2b_sops = 0;
			idle_phase = 1'b1;
		end
		else
		begin
			// quiet window from reset release to the first sink word
			if (sink_valid)
				idle_phase = 1'b0;
			if (idle_phase && (source_valid !== 1'b0))
				report_mismatch(test_name(0), "source_valid", 0, 32'd0, 32'(source_valid));
			if (idle_phase && (sink_idle !== 1'b1))
				report_mismatch(test_name(0), "sink_idle", 0, 32'd1, 32'(sink_idle));

			// input frame capture restarts on sop
			if (sink_valid)
			begin
				if (sink_sop)
				begin
					cap_idx = 0;
					// later back-to-back frames start before the previous one has left
					if ((test_id == 3) && (b2b_sops > 0) && (tid_q.size() == 0))
					begin
						$display("error: back-to-back frame started with no frame still sourcing");
						error_count++;
					end
					if (test_id == 3)
						b2b_sops++;
				end
				cap[cap_idx] = sink_data;
				cap_idx++;
				if (cap_idx == DFT_PTS)
				begin
					expected = ref_frame(cap);
					for (int j = 0; j < DFT_PTS; j++)
						exp_q.push_back(expected[j]);
					tid_q.push_back(test_id);
					cap_idx = 0;
				end
			end

			if (source_valid)
			begin
				if (exp_q.size() == 0)
				begin
					$display("error: source_valid is high with no input frame waiting for output");
					error_count++;
				end
				else
				begin
					name = test_name(tid_q[0]);
					want = exp_q.pop_front();
					if (source_data !== want)
						report_mismatch(name, "data", out_idx, want, source_data);
					if (source_sop !== (out_idx == 0))
						report_mismatch(name, "sop", out_idx, 32'(out_idx == 0), 32'(source_sop));
					if (source_eop !== (out_idx == DFT_PTS - 1))
						report_mismatch(name, "eop", out_idx, 32'(out_idx == DFT_PTS - 1),
							32'(source_eop));
					out_idx++;
					if (out_idx == DFT_PTS)
					begin
						out_idx = 0;
						void'(tid_q.pop_front());
						frames_done++;
					end
				end
			end
			// framing has no holes between sop and eop
			else if (out_idx != 0)
			begin
				$display("error: source_valid dropped inside a frame after %0d words", out_idx);
				error_count++;
				out_idx = 0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/mrd_dft_tb.sv ====
// testbench top for mrd_dft_top; drives frames, bounds the run and prints the verdict
`default_nettype none

module mrd_dft_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import mrd_pkg::*;

	// one counting frame, two gapped random frames, four back-to-back frames
	localparam int NUM_FRAMES = 7;
	localparam int TIMEOUT_CYCLES = (NUM_FRAMES + 1) * 400;

	logic clk;
	logic rst_n;
	logic sink_valid;
	logic sink_sop;
	logic [DATA_W-1:0] sink_data;
	logic sink_idle;
	logic source_valid;
	logic source_sop;
	logic source_eop;
	logic [DATA_W-1:0] source_data;

	integer seed;
	int test_id;
	int frames_sent;
	int cycle_cnt;
	int check_errors;
	int frames_done;

	mrd_dft_top dut (
		.clk(clk), .rst_n(rst_n),
		.sink_valid(sink_valid), .sink_sop(sink_sop), .sink_data(sink_data),
		.sink_idle(sink_idle), .source_valid(source_valid), .source_sop(source_sop),
		.source_eop(source_eop), .source_data(source_data)
	);

	mrd_dft_checker chk (
		.clk(clk), .rst_n(rst_n), .test_id(test_id),
		.sink_valid(sink_valid), .sink_sop(sink_sop), .sink_data(sink_data),
		.sink_idle(sink_idle), .source_valid(source_valid), .source_sop(source_sop),
		.source_eop(source_eop), .source_data(source_data),
		.error_count(check_errors), .frames_done(frames_done)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// ------------------------------------------------------------------------
	// run limit
	// ------------------------------------------------------------------------
	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles: only %0d of %0d frames came out, errors %0d",
				cycle_cnt, frames_done, frames_sent, check_errors);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	// one frame of DFT_PTS words, waits for sink_idle first
	task automatic send_frame(input bit random_data, input bit with_gaps);
		int gap;
		while (!sink_idle)
			@(negedge clk);
		for (int k = 0; k < DFT_PTS; k++)
		begin
			// idle holes inside the frame, never before sop
			if (with_gaps && (k > 0) && (($random(seed) & 3) == 0))
			begin
				gap = 1 + ($random(seed) & 3);
				sink_valid = 1'b0;
				sink_sop = 1'b0;
				repeat (gap)
					@(negedge clk);
			end
			sink_valid = 1'b1;
			sink_sop = (k == 0);
			sink_data = random_data ? DATA_W'($random(seed)) : DATA_W'(k);
			@(negedge clk);
		end
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		frames_sent++;
	endtask

	// until the checker has seen every frame sent so far
	task automatic wait_frames_out();
		while (frames_done < frames_sent)
			@(negedge clk);
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_data = '0;
		seed = 32'hca37_0288;
		test_id = 0;
		frames_sent = 0;
		cycle_cnt = 0;

		repeat (16)
			@(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// quiet window, checker watches source_valid and sink_idle
		repeat (24)
			@(negedge clk);

		test_id = 1;
		send_frame(1'b0, 1'b0);
		wait_frames_out();

		test_id = 2;
		repeat (2)
			send_frame(1'b1, 1'b1);
		wait_frames_out();

		// next frame starts as soon as sink_idle rises
		test_id = 3;
		repeat (4)
			send_frame(1'b1, 1'b0);
		wait_frames_out();

		// trailing window catches stray output words
		repeat (40)
			@(negedge clk);

		$display("errors: %0d, frames checked: %0d of %0d", check_errors, frames_done,
			frames_sent);
		if ((check_errors == 0) && (frames_done == NUM_FRAMES))
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mrd_dft_top.f ====
src/mrd_pkg.sv
src/mrd_stride_addr.sv
src/mrd_mem_bank.sv
src/mrd_ctrl_fsm.sv
src/mrd_dft_top.sv
tb/mrd_dft_asserts.sv
tb/mrd_dft_checker.sv
tb/mrd_dft_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mrd_dft_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --assert -Wno-fatal --top-module mrd_dft_tb -f mrd_dft_top.f

status=0
./obj_dir/Vmrd_dft_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log
then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
